//--- src/vertex_pkg.sv
package vertex_pkg;

	////////////////////////////////////////////////////////////////////////
	// widths and batch constants
	////////////////////////////////////////////////////////////////////////
	localparam int vertex_bits      = 32;  // one field, also the vertex id
	localparam int vertex_bytes     = 4;
	localparam int cl_vertex_num    = 4;   // fields per cacheline
	localparam int cacheline_bits   = 128;
	localparam int cacheline_bytes  = 16;  // offset step per batch
	localparam int addr_bits        = 32;
	localparam int size_bits        = 8;
	localparam int job_bits         = 128; // id, in_degree, out_degree, edges_idx
	localparam int fifo_depth       = 32;
	localparam int outstanding_bits = 4;

	// which per-vertex array a command or response belongs to
	typedef enum logic [1:0] {
		IN_DEGREE,
		OUT_DEGREE,
		EDGES_IDX
	} vertex_struct_t;

	typedef enum logic [3:0] {
		SEQ_RESET,
		SEQ_INIT,
		SEQ_WAIT,
		SEQ_CALC_SIZE,
		SEQ_IDLE,
		SEQ_SEND_IN_DEGREE,
		SEQ_SEND_OUT_DEGREE,
		SEQ_SEND_EDGES_IDX
	} seq_state_t;

	// read requests must be a power of two in bytes
	function automatic logic [size_bits-1:0] request_size_of(input logic [size_bits-1:0] count);
		int bytes;
		int size;
		bytes = count * vertex_bytes;
		size  = 1;
		for (int i = 0; i < size_bits; i++) begin
			if (size < bytes)
				size = size * 2;
		end
		return size[size_bits-1:0];
	endfunction

endpackage

//--- src/vertex_read_sequencer.sv
`timescale 1ns/100ps

module vertex_read_sequencer (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  start,
	input  logic [vertex_pkg::vertex_bits-1:0]    num_vertices,
	input  logic [vertex_pkg::addr_bits-1:0]      in_degree_base,
	input  logic [vertex_pkg::addr_bits-1:0]      out_degree_base,
	input  logic [vertex_pkg::addr_bits-1:0]      edges_idx_base,
	input  logic                                  read_almost_full,
	input  logic                                  resp_valid,
	input  logic                                  streams_pending,
	input  logic [$clog2(vertex_pkg::fifo_depth+1)-1:0] fifo_level,
	input  logic                                  fifo_almost_full,
	output logic                                  cmd_valid,
	output logic [vertex_pkg::addr_bits-1:0]      cmd_address,
	output logic [vertex_pkg::size_bits-1:0]      cmd_size,
	output logic [vertex_pkg::size_bits-1:0]      cmd_real_size,
	output vertex_pkg::vertex_struct_t            cmd_struct,
	output logic                                  shift_start
);

	vertex_pkg::seq_state_t state, next_state;

	logic [vertex_pkg::addr_bits-1:0]        in_base_q;
	logic [vertex_pkg::addr_bits-1:0]        out_base_q;
	logic [vertex_pkg::addr_bits-1:0]        edges_base_q;
	logic [vertex_pkg::addr_bits-1:0]        offset;      // running offset into each array
	logic [vertex_pkg::vertex_bits-1:0]      remaining;   // vertices not yet requested
	logic [vertex_pkg::size_bits-1:0]        batch_next;
	logic [vertex_pkg::outstanding_bits-1:0] outstanding;
	logic batch_ready;
	logic job_done;

	assign batch_ready = (remaining != '0) && (outstanding == '0) && !streams_pending &&
		(fifo_level < vertex_pkg::fifo_depth - vertex_pkg::cl_vertex_num);
	assign job_done    = (remaining == '0) && (outstanding == '0) && !streams_pending;

	// one cacheline worth of vertices, or whatever is left
	assign batch_next = (remaining >= vertex_pkg::cl_vertex_num) ?
		vertex_pkg::size_bits'(vertex_pkg::cl_vertex_num) :
		remaining[vertex_pkg::size_bits-1:0];

	////////////////////////////////////////////////////////////////////////
	// batch state machine
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			state <= vertex_pkg::SEQ_RESET;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			vertex_pkg::SEQ_RESET: begin
				if (start)
					next_state = vertex_pkg::SEQ_INIT;
			end
			vertex_pkg::SEQ_INIT: begin
				next_state = vertex_pkg::SEQ_WAIT;
			end
			vertex_pkg::SEQ_WAIT: begin
				if (batch_ready)
					next_state = vertex_pkg::SEQ_CALC_SIZE;
				else if (job_done)
					next_state = vertex_pkg::SEQ_RESET; // ready for another start
			end
			vertex_pkg::SEQ_CALC_SIZE: begin
				next_state = vertex_pkg::SEQ_IDLE;
			end
			vertex_pkg::SEQ_IDLE: begin
				if (!read_almost_full)
					next_state = vertex_pkg::SEQ_SEND_IN_DEGREE;
			end
			vertex_pkg::SEQ_SEND_IN_DEGREE: begin
				if (!read_almost_full)
					next_state = vertex_pkg::SEQ_SEND_OUT_DEGREE;
			end
			vertex_pkg::SEQ_SEND_OUT_DEGREE: begin
				if (!read_almost_full)
					next_state = vertex_pkg::SEQ_SEND_EDGES_IDX;
			end
			vertex_pkg::SEQ_SEND_EDGES_IDX: begin
				if (!read_almost_full)
					next_state = vertex_pkg::SEQ_WAIT;
			end
			default: next_state = vertex_pkg::SEQ_RESET;
		endcase
	end

	// vertices left to request, counted down per batch
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining <= '0;
		end else begin
			if (state == vertex_pkg::SEQ_RESET && start)
				remaining <= num_vertices;
			else if (state == vertex_pkg::SEQ_CALC_SIZE)
				remaining <= remaining - batch_next;
		end
	end

	always_ff @(posedge clock) begin
		case (state)
			vertex_pkg::SEQ_RESET: begin
				if (start) begin
					in_base_q    <= in_degree_base;
					out_base_q   <= out_degree_base;
					edges_base_q <= edges_idx_base;
				end
			end
			vertex_pkg::SEQ_INIT: offset <= '0;
			vertex_pkg::SEQ_CALC_SIZE: begin
				cmd_real_size <= batch_next;
				cmd_size      <= vertex_pkg::request_size_of(batch_next);
			end
			vertex_pkg::SEQ_SEND_EDGES_IDX: begin
				if (!read_almost_full) // last command of the batch
					offset <= offset + vertex_pkg::addr_bits'(vertex_pkg::cacheline_bytes);
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////////////////
	// command outputs
	////////////////////////////////////////////////////////////////////////
	assign cmd_valid = !read_almost_full && (state inside {vertex_pkg::SEQ_SEND_IN_DEGREE,
		vertex_pkg::SEQ_SEND_OUT_DEGREE, vertex_pkg::SEQ_SEND_EDGES_IDX});

	always_comb begin
		case (state)
			vertex_pkg::SEQ_SEND_OUT_DEGREE: begin
				cmd_address = out_base_q + offset;
				cmd_struct  = vertex_pkg::OUT_DEGREE;
			end
			vertex_pkg::SEQ_SEND_EDGES_IDX: begin
				cmd_address = edges_base_q + offset;
				cmd_struct  = vertex_pkg::EDGES_IDX;
			end
			default: begin
				cmd_address = in_base_q + offset;
				cmd_struct  = vertex_pkg::IN_DEGREE;
			end
		endcase
	end

	// outstanding responses go up per command and down per response
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn)
			outstanding <= '0;
		else if (cmd_valid && !resp_valid)
			outstanding <= outstanding + 1'b1;
		else if (resp_valid && !cmd_valid)
			outstanding <= outstanding - 1'b1;
	end

	// streams move together once every line of the batch has landed
	assign shift_start = (outstanding == '0) && streams_pending && !fifo_almost_full;

	a_outstanding_range: assert property (@(posedge clock) disable iff (!rstn)
		!(cmd_valid && !resp_valid && outstanding == '1) &&
		!(resp_valid && !cmd_valid && outstanding == '0));

	// a held-off command keeps its array and address until it goes out
	a_held_cmd_kept: assert property (@(posedge clock) disable iff (!rstn)
		(read_almost_full && state inside {vertex_pkg::SEQ_SEND_IN_DEGREE,
		vertex_pkg::SEQ_SEND_OUT_DEGREE, vertex_pkg::SEQ_SEND_EDGES_IDX}) |=>
		($stable(cmd_struct) && $stable(cmd_address)));

endmodule

//--- src/cacheline_stream.sv
`timescale 1ns/100ps

module cacheline_stream #(
	parameter vertex_pkg::vertex_struct_t struct_tag = vertex_pkg::IN_DEGREE
) (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  resp_valid,
	input  vertex_pkg::vertex_struct_t            resp_struct,
	input  logic [vertex_pkg::size_bits-1:0]      resp_real_size,
	input  logic [vertex_pkg::cacheline_bits-1:0] resp_data,
	input  logic                                  shift_start,
	output logic [vertex_pkg::vertex_bits-1:0]    field,
	output logic                                  field_valid,
	output logic                                  pending
);

	logic [vertex_pkg::cacheline_bits-1:0] line;
	logic [vertex_pkg::size_bits-1:0]      count; // fields still to shift out
	logic take;
	logic shift;

	assign take  = resp_valid && (resp_struct == struct_tag);
	assign shift = shift_start && pending;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending <= 1'b0;
			count   <= '0;
		end else if (take) begin
			pending <= (resp_real_size != '0);
			count   <= resp_real_size;
		end else if (shift) begin
			count <= count - 1'b1;
			if (count == 1)
				pending <= 1'b0; // last field going out
		end
	end

	// field 0 sits in the low bits
	always_ff @(posedge clock) begin
		if (take)
			line <= resp_data;
		else if (shift)
			line <= line >> vertex_pkg::vertex_bits;
	end

	assign field       = line[vertex_pkg::vertex_bits-1:0];
	assign field_valid = shift;

	// sequencer waits for pending to drop before the next batch
	a_no_overwrite: assert property (@(posedge clock) disable iff (!rstn)
		take |-> !pending);

endmodule

//--- src/vertex_assembler.sv
`timescale 1ns/100ps

module vertex_assembler (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic [vertex_pkg::vertex_bits-1:0] in_degree,
	input  logic [vertex_pkg::vertex_bits-1:0] out_degree,
	input  logic [vertex_pkg::vertex_bits-1:0] edges_idx,
	input  logic                               in_valid,
	input  logic                               out_valid,
	input  logic                               edges_valid,
	input  logic                               in_pending,
	input  logic                               out_pending,
	input  logic                               edges_pending,
	output logic                               push,
	output logic [vertex_pkg::job_bits-1:0]    push_data,
	output logic                               streams_pending,
	output logic [vertex_pkg::vertex_bits-1:0] filtered_count
);

	logic [vertex_pkg::job_bits-1:0]    job_q;
	logic [vertex_pkg::vertex_bits-1:0] next_id;
	logic                               job_valid_q;
	logic                               all_valid;
	logic                               no_out_edges;

	assign all_valid       = in_valid && out_valid && edges_valid;
	assign streams_pending = in_pending || out_pending || edges_pending;

	////////////////////////////////////////////////////////////////////////
	// job register, id counter and filter counter
	////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			job_valid_q    <= 1'b0;
			next_id        <= '0;
			filtered_count <= '0;
		end else begin
			job_valid_q <= all_valid;
			if (all_valid)
				next_id <= next_id + 1'b1; // filtered vertices use up an id too
			if (job_valid_q && no_out_edges)
				filtered_count <= filtered_count + 1'b1;
		end
	end

	// word layout, low to high: id, in_degree, out_degree, edges_idx
	always_ff @(posedge clock) begin
		if (all_valid)
			job_q <= {edges_idx, out_degree, in_degree, next_id};
	end

	assign no_out_edges = (job_q[3*vertex_pkg::vertex_bits-1:2*vertex_pkg::vertex_bits] == '0);
	assign push         = job_valid_q && !no_out_edges;
	assign push_data    = job_q;

	// streams are started by one shared shift_start
	a_lockstep: assert property (@(posedge clock) disable iff (!rstn)
		(in_valid == out_valid) && (out_valid == edges_valid));

endmodule

//--- src/job_fifo.sv
`timescale 1ns/100ps

module job_fifo #(
	parameter int width = vertex_pkg::job_bits,
	parameter int depth = vertex_pkg::fifo_depth
) (
	input  logic                         clock,
	input  logic                         rstn,
	input  logic                         push,
	input  logic [width-1:0]             data_in,
	input  logic                         pop,
	output logic [width-1:0]             data_out,
	output logic                         valid,
	output logic [$clog2(depth+1)-1:0]   level,
	output logic                         almost_full
);

	logic [width-1:0]           mem [depth];
	logic [$clog2(depth)-1:0]   wr_ptr;
	logic [$clog2(depth)-1:0]   rd_ptr;
	logic                       do_pop;

	assign do_pop = pop && valid;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
			if (push && !do_pop)
				level <= level + 1'b1;
			else if (do_pop && !push)
				level <= level - 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (push)
			mem[wr_ptr] <= data_in;
	end

	// show-ahead head
	assign data_out    = mem[rd_ptr];
	assign valid       = (level != '0);
	assign almost_full = (level > depth - vertex_pkg::cl_vertex_num); // < one batch free

	a_no_overflow: assert property (@(posedge clock) disable iff (!rstn)
		push |-> (level < depth));

	a_no_underflow: assert property (@(posedge clock) disable iff (!rstn)
		pop |-> valid);

endmodule

//--- src/vertex_job_control.sv
`timescale 1ns/100ps

module vertex_job_control (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  start,
	input  logic [vertex_pkg::vertex_bits-1:0]    num_vertices,
	input  logic [vertex_pkg::addr_bits-1:0]      in_degree_base,
	input  logic [vertex_pkg::addr_bits-1:0]      out_degree_base,
	input  logic [vertex_pkg::addr_bits-1:0]      edges_idx_base,
	input  logic                                  read_almost_full,
	output logic                                  cmd_valid,
	output logic [vertex_pkg::addr_bits-1:0]      cmd_address,
	output logic [vertex_pkg::size_bits-1:0]      cmd_size,
	output logic [vertex_pkg::size_bits-1:0]      cmd_real_size,
	output vertex_pkg::vertex_struct_t            cmd_struct,
	input  logic                                  resp_valid,
	input  vertex_pkg::vertex_struct_t            resp_struct,
	input  logic [vertex_pkg::size_bits-1:0]      resp_real_size,
	input  logic [vertex_pkg::cacheline_bits-1:0] resp_data,
	input  logic                                  job_request,
	output logic                                  job_valid,
	output logic [vertex_pkg::job_bits-1:0]       job_data,
	output logic [vertex_pkg::vertex_bits-1:0]    filtered_count
);

	logic shift_start;
	logic streams_pending;
	logic push;
	logic fifo_almost_full;
	logic [vertex_pkg::job_bits-1:0]              push_data;
	logic [$clog2(vertex_pkg::fifo_depth+1)-1:0]  fifo_level;

	// one field, valid and pending per array
	logic [vertex_pkg::vertex_bits-1:0] in_field, out_field, edges_field;
	logic in_valid, out_valid, edges_valid;
	logic in_pending, out_pending, edges_pending;

	////////////////////////////////////////////////////////////////////////
	// read command side
	////////////////////////////////////////////////////////////////////////
	vertex_read_sequencer u_sequencer (
		.clock            (clock),
		.rstn             (rstn),
		.start            (start),
		.num_vertices     (num_vertices),
		.in_degree_base   (in_degree_base),
		.out_degree_base  (out_degree_base),
		.edges_idx_base   (edges_idx_base),
		.read_almost_full (read_almost_full),
		.resp_valid       (resp_valid),
		.streams_pending  (streams_pending),
		.fifo_level       (fifo_level),
		.fifo_almost_full (fifo_almost_full),
		.cmd_valid        (cmd_valid),
		.cmd_address      (cmd_address),
		.cmd_size         (cmd_size),
		.cmd_real_size    (cmd_real_size),
		.cmd_struct       (cmd_struct),
		.shift_start      (shift_start)
	);

	////////////////////////////////////////////////////////////////////////
	// per-array cacheline streams
	////////////////////////////////////////////////////////////////////////
	cacheline_stream #(.struct_tag(vertex_pkg::IN_DEGREE)) u_in_degree_stream (
		.clock(clock), .rstn(rstn),
		.resp_valid(resp_valid), .resp_struct(resp_struct),
		.resp_real_size(resp_real_size), .resp_data(resp_data),
		.shift_start(shift_start),
		.field(in_field), .field_valid(in_valid), .pending(in_pending)
	);

	cacheline_stream #(.struct_tag(vertex_pkg::OUT_DEGREE)) u_out_degree_stream (
		.clock(clock), .rstn(rstn),
		.resp_valid(resp_valid), .resp_struct(resp_struct),
		.resp_real_size(resp_real_size), .resp_data(resp_data),
		.shift_start(shift_start),
		.field(out_field), .field_valid(out_valid), .pending(out_pending)
	);

	cacheline_stream #(.struct_tag(vertex_pkg::EDGES_IDX)) u_edges_idx_stream (
		.clock(clock), .rstn(rstn),
		.resp_valid(resp_valid), .resp_struct(resp_struct),
		.resp_real_size(resp_real_size), .resp_data(resp_data),
		.shift_start(shift_start),
		.field(edges_field), .field_valid(edges_valid), .pending(edges_pending)
	);

	////////////////////////////////////////////////////////////////////////
	// job assembly and buffering
	////////////////////////////////////////////////////////////////////////
	vertex_assembler u_assembler (
		.clock           (clock),
		.rstn            (rstn),
		.in_degree       (in_field),
		.out_degree      (out_field),
		.edges_idx       (edges_field),
		.in_valid        (in_valid),
		.out_valid       (out_valid),
		.edges_valid     (edges_valid),
		.in_pending      (in_pending),
		.out_pending     (out_pending),
		.edges_pending   (edges_pending),
		.push            (push),
		.push_data       (push_data),
		.streams_pending (streams_pending),
		.filtered_count  (filtered_count)
	);

	job_fifo #(
		.width (vertex_pkg::job_bits),
		.depth (vertex_pkg::fifo_depth)
	) u_job_fifo (
		.clock       (clock),
		.rstn        (rstn),
		.push        (push),
		.data_in     (push_data),
		.pop         (job_request),
		.data_out    (job_data),
		.valid       (job_valid),
		.level       (fifo_level),
		.almost_full (fifo_almost_full)
	);

endmodule

//--- testbench/tb_memory_model.sv
`timescale 1ns/100ps

module tb_memory_model (
	input  logic                                  clock,
	input  logic                                  rstn,
	input  logic                                  cmd_valid,
	input  logic [vertex_pkg::addr_bits-1:0]      cmd_address,
	input  logic [vertex_pkg::size_bits-1:0]      cmd_real_size,
	input  vertex_pkg::vertex_struct_t            cmd_struct,
	output logic                                  read_almost_full,
	output logic                                  resp_valid,
	output vertex_pkg::vertex_struct_t            resp_struct,
	output logic [vertex_pkg::size_bits-1:0]      resp_real_size,
	output logic [vertex_pkg::cacheline_bits-1:0] resp_data
);

	localparam int mem_words = 512; // 2 KB of 32-bit words

	logic [31:0] mem [mem_words];
	int cycle;
	int last_due;
	int due;

	// commands waiting for their answer, oldest first
	int                                   due_q[$];
	logic [vertex_pkg::addr_bits-1:0]     addr_q[$];
	logic [vertex_pkg::size_bits-1:0]     size_q[$];
	vertex_pkg::vertex_struct_t           struct_q[$];

	function automatic logic [vertex_pkg::cacheline_bits-1:0] line_at(
		input logic [vertex_pkg::addr_bits-1:0] address);
		logic [vertex_pkg::cacheline_bits-1:0] line;
		for (int k = 0; k < vertex_pkg::cl_vertex_num; k++)
			line[k*32 +: 32] = mem[((address >> 2) + k) % mem_words];
		return line;
	endfunction

	initial begin
		read_almost_full = 1'b0;
		resp_valid       = 1'b0;
		resp_struct      = vertex_pkg::IN_DEGREE;
		resp_real_size   = '0;
		resp_data        = '0;
		cycle            = 0;
		last_due         = 0;
		@(posedge rstn);
		// about one word in four is zero, out_degree included
		for (int i = 0; i < mem_words; i++)
			mem[i] = ($urandom_range(3) == 0) ? 32'd0 : $urandom_range(1000, 1);
	end

	always @(posedge clock) begin
		cycle = cycle + 1;
		if (!rstn) begin
			read_almost_full <= 1'b0;
			resp_valid       <= 1'b0;
			due_q.delete();
			addr_q.delete();
			size_q.delete();
			struct_q.delete();
		end else begin
			read_almost_full <= ($urandom_range(3) == 0);
			if (cmd_valid) begin
				due = cycle + $urandom_range(9, 2);
				if (due <= last_due)
					due = last_due + 1; // keep answers in command order
				last_due = due;
				due_q.push_back(due);
				addr_q.push_back(cmd_address);
				size_q.push_back(cmd_real_size);
				struct_q.push_back(cmd_struct);
			end
			resp_valid <= 1'b0;
			if (due_q.size() > 0 && due_q[0] <= cycle) begin
				void'(due_q.pop_front());
				resp_valid     <= 1'b1;
				resp_struct    <= struct_q.pop_front();
				resp_real_size <= size_q.pop_front();
				resp_data      <= line_at(addr_q.pop_front());
			end
		end
	end

endmodule

//--- testbench/tb_vertex_job_control.sv
`timescale 1ns/100ps

module tb_vertex_job_control;

	localparam int cycle_limit = 400 * (10 + 40); // both job runs

	logic clock = 1'b0;
	logic rstn;
	logic start;
	logic [vertex_pkg::vertex_bits-1:0]    num_vertices;
	logic [vertex_pkg::addr_bits-1:0]      in_degree_base;
	logic [vertex_pkg::addr_bits-1:0]      out_degree_base;
	logic [vertex_pkg::addr_bits-1:0]      edges_idx_base;
	logic                                  read_almost_full;
	logic                                  cmd_valid;
	logic [vertex_pkg::addr_bits-1:0]      cmd_address;
	logic [vertex_pkg::size_bits-1:0]      cmd_size;
	logic [vertex_pkg::size_bits-1:0]      cmd_real_size;
	vertex_pkg::vertex_struct_t            cmd_struct;
	logic                                  resp_valid;
	vertex_pkg::vertex_struct_t            resp_struct;
	logic [vertex_pkg::size_bits-1:0]      resp_real_size;
	logic [vertex_pkg::cacheline_bits-1:0] resp_data;
	logic                                  job_request;
	logic                                  job_valid;
	logic [vertex_pkg::job_bits-1:0]       job_data;
	logic [vertex_pkg::vertex_bits-1:0]    filtered_count;

	int errors;
	int tests_run;
	int tests_ok;
	int cycle;
	int cmd_count;
	int pop_count;
	int exp_count;
	int exp_filtered;
	int exp_cmds;
	int run_vertices;
	logic [vertex_pkg::addr_bits-1:0] run_base [3];
	logic idle;        // between reset and start
	logic long_pauses; // consumer holds off for long stretches
	logic [vertex_pkg::job_bits-1:0] exp_jobs [64];
	logic [vertex_pkg::job_bits-1:0] exp_job;

	// expected command from the batch rule
	int batch;
	int slot;
	int exp_real;
	int exp_size;
	logic [vertex_pkg::addr_bits-1:0] exp_address;
	vertex_pkg::vertex_struct_t       exp_struct;

	vertex_job_control dut (.*);

	tb_memory_model memory (
		.clock(clock), .rstn(rstn),
		.cmd_valid(cmd_valid), .cmd_address(cmd_address),
		.cmd_real_size(cmd_real_size), .cmd_struct(cmd_struct),
		.read_almost_full(read_almost_full), .resp_valid(resp_valid),
		.resp_struct(resp_struct), .resp_real_size(resp_real_size), .resp_data(resp_data)
	);

	always #20 clock = ~clock;

	function automatic int bytes_rounded_up(input int n);
		int p;
		p = 1;
		while (p < n)
			p = p * 2;
		return p;
	endfunction

	always_comb begin
		batch       = cmd_count / 3;
		slot        = cmd_count % 3;
		exp_real    = run_vertices - 4 * batch;
		if (exp_real > 4)
			exp_real = 4;
		exp_size    = bytes_rounded_up(exp_real * 4);
		exp_address = run_base[slot] + 16 * batch;
		exp_struct  = vertex_pkg::vertex_struct_t'(slot);
	end

	assign exp_job = (pop_count < 64) ? exp_jobs[pop_count] : '0;

	//////////////////////////////////////////////////////////////////////
	// counters, consumer, timeout
	//////////////////////////////////////////////////////////////////////
	always @(posedge clock) begin
		if (!rstn) begin
			cmd_count <= 0;
			pop_count <= 0;
		end else begin
			if (cmd_valid)
				cmd_count <= cmd_count + 1;
			if (job_valid && job_request)
				pop_count <= pop_count + 1;
		end
	end

	// request only on a cycle after no pop, so a request never meets an empty FIFO
	always @(posedge clock) begin
		if (!rstn)
			job_request <= 1'b0;
		else if (long_pauses)
			job_request <= (cycle % 500 >= 400) && job_valid && !job_request; // FIFO fills up
		else
			job_request <= ($urandom_range(3) != 0) && job_valid && !job_request;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
		if (cycle >= cycle_limit) begin
			$display("run stopped: cycle limit of %0d reached before the tests ended", cycle_limit);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////
	a_quiet_before_start: assert property (@(posedge clock) disable iff (!rstn)
		idle |-> (!cmd_valid && !job_valid && filtered_count == '0))
	else begin
		errors++;
		$display("ERROR %0t: output active before start", $time);
	end

	a_cmd_fields: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> (cmd_struct == exp_struct && cmd_address == exp_address &&
		cmd_real_size == vertex_pkg::size_bits'(exp_real) &&
		cmd_size == vertex_pkg::size_bits'(exp_size)))
	else begin
		errors++;
		$display("ERROR %0t: read command %0d has wrong array, address or size",
			$time, $sampled(cmd_count));
	end

	a_cmd_held_off: assert property (@(posedge clock) disable iff (!rstn)
		cmd_valid |-> !read_almost_full)
	else begin
		errors++;
		$display("ERROR %0t: read command issued while read_almost_full", $time);
	end

	a_job_in_order: assert property (@(posedge clock) disable iff (!rstn)
		(job_valid && job_request) |-> (pop_count < exp_count && job_data == exp_job))
	else begin
		errors++;
		$display("ERROR %0t: popped job %0d is %h", $time, $sampled(pop_count),
			$sampled(job_data));
	end

	a_job_held: assert property (@(posedge clock) disable iff (!rstn)
		(job_valid && !job_request) |=> job_valid)
	else begin
		errors++;
		$display("ERROR %0t: job_valid fell with a job still queued", $time);
	end

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////
	task automatic apply_reset();
		@(posedge clock);
		rstn <= 1'b0;
		idle <= 1'b1;
		repeat (3) @(posedge clock);
		rstn <= 1'b1;
	endtask

	task automatic build_expected(input int nv, input logic [31:0] in_b, out_b, edges_b);
		logic [31:0] in_d;
		logic [31:0] out_d;
		logic [31:0] edges_d;
		exp_count    = 0;
		exp_filtered = 0;
		exp_cmds     = 3 * ((nv + 3) / 4);
		for (int i = 0; i < nv; i++) begin
			in_d    = memory.mem[(in_b >> 2) + i];
			out_d   = memory.mem[(out_b >> 2) + i];
			edges_d = memory.mem[(edges_b >> 2) + i];
			if (out_d == 0) begin
				exp_filtered++; // filtered vertex still takes an id
			end else begin
				exp_jobs[exp_count] = {edges_d, out_d, in_d, 32'(i)};
				exp_count++;
			end
		end
	endtask

	task automatic run_job(input int nv, input logic [31:0] in_b, out_b, edges_b,
		input logic pauses);
		@(posedge clock);
		build_expected(nv, in_b, out_b, edges_b);
		run_vertices    <= nv;
		run_base[0]     <= in_b;
		run_base[1]     <= out_b;
		run_base[2]     <= edges_b;
		long_pauses     <= pauses;
		idle            <= 1'b0;
		start           <= 1'b1;
		num_vertices    <= nv;
		in_degree_base  <= in_b;
		out_degree_base <= out_b;
		edges_idx_base  <= edges_b;
		@(posedge clock);
		start <= 1'b0;
		while (pop_count < exp_count || cmd_count < exp_cmds || filtered_count < exp_filtered)
			@(posedge clock);
		repeat (4) @(posedge clock); // room for a stray extra job
		assert (cmd_count == exp_cmds) else begin
			errors++;
			$display("ERROR %0t: %0d read commands sent, %0d expected", $time,
				cmd_count, exp_cmds);
		end
		assert (filtered_count == exp_filtered && pop_count == exp_count && !job_valid) else begin
			errors++;
			$display("ERROR %0t: filtered %0d popped %0d, expected %0d and %0d", $time,
				filtered_count, pop_count, exp_filtered, exp_count);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			tests_ok++;
			$display("%s: ok", name);
		end else begin
			$display("%s: not ok, %0d errors", name, errors - errors_before);
		end
	endtask

	initial begin
		int errors_before;
		void'($urandom(87752));
		errors          = 0;
		tests_run       = 0;
		tests_ok        = 0;
		cycle           = 0;
		rstn            = 1'b0;
		start           = 1'b0;
		num_vertices    = '0;
		in_degree_base  = '0;
		out_degree_base = '0;
		edges_idx_base  = '0;
		job_request     = 1'b0;
		idle            = 1'b1;
		long_pauses     = 1'b0;
		run_vertices    = 0;
		run_base[0]     = '0;
		run_base[1]     = '0;
		run_base[2]     = '0;

		apply_reset();
		errors_before = errors;
		repeat (12) @(posedge clock);
		report_test("reset, outputs quiet before start", errors_before);

		errors_before = errors;
		run_job(10, 32'h000, 32'h100, 32'h200, 1'b0);
		report_test("10 vertices, batches and filtering", errors_before);

		apply_reset();
		errors_before = errors;
		run_job(40, 32'h400, 32'h500, 32'h600, 1'b1);
		report_test("40 vertices, consumer pauses", errors_before);

		$display("tests run: %0d, ok: %0d, not ok: %0d, errors: %0d",
			tests_run, tests_ok, tests_run - tests_ok, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- list.f
src/vertex_pkg.sv
src/vertex_read_sequencer.sv
src/cacheline_stream.sv
src/vertex_assembler.sv
src/job_fifo.sv
src/vertex_job_control.sv
testbench/tb_memory_model.sv
testbench/tb_vertex_job_control.sv
